//--- source/lsu_pkg.sv
// Shared LSU types. Data and address are fixed at 32 bits, and AXI4-Lite prot is not used
package lsu_pkg;

    localparam int data_w = 32;                    // Data and address width

    localparam logic [1:0] axi_resp_okay = 2'd0;   // OKAY response code

    // Access size as it comes from the pipeline
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2,
        size_bad  = 2'd3                           // Reserved encoding, raises op_fault
    } lsu_size_e;

    typedef struct packed {
        logic              is_write;
        logic              is_unsigned;            // Zero-extend reads
        lsu_size_e         size;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;                  // Write data, right aligned
    } lsu_req_t;

    typedef struct packed {
        logic              is_write;
        logic              is_unsigned;
        lsu_size_e         size;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] lane_data;              // Write data moved to its byte lane
        logic [3:0]        strb;
        logic              op_fault;
        logic              addr_fault;
        logic              access_fault;
    } lsu_dec_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;                  // Extended read data, 0 otherwise
        logic              op_fault;
        logic              addr_fault;
        logic              access_fault;
    } lsu_rsp_t;

    typedef struct packed {
        logic [data_w-1:0] addr;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [3:0]        strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

endpackage

//--- source/lsu_decode.sv
// Decode slot; req must hold while stalled, and the window must not wrap past 2^32
`timescale 1ns/1ns

module lsu_decode #(
    parameter logic [31:0] win_base = 32'h0000_0000,
    parameter logic [31:0] win_size = 32'h0001_0000
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              dec_valid,
    input  logic              dec_ready,
    output lsu_pkg::lsu_dec_t dec
);

    logic              run;                        // Opens the port one cycle after reset
    logic [2:0]        nbytes;
    logic [32:0]       range_end;
    logic [32:0]       win_end;
    logic              is_bad;
    logic              misaligned;
    logic              outside;
    lsu_pkg::lsu_dec_t dec_next;

    assign win_end   = {1'b0, win_base} + {1'b0, win_size};
    assign range_end = {1'b0, req.addr} + {30'b0, nbytes};  // One past the last byte

    assign is_bad     = (req.size == lsu_pkg::size_bad);
    assign misaligned = (req.size == lsu_pkg::size_half && req.addr[0]) ||
                        (req.size == lsu_pkg::size_word && req.addr[1:0] != 2'b00);
    assign outside    = (req.addr < win_base) || (range_end > win_end);

    always_comb begin
        nbytes = 3'd4;
        dec_next = '0;
        dec_next.is_write    = req.is_write;
        dec_next.is_unsigned = req.is_unsigned;
        dec_next.size        = req.size;
        dec_next.addr        = req.addr;
        dec_next.lane_data   = req.wdata << {req.addr[1:0], 3'b000};
        case (req.size)
            lsu_pkg::size_byte: begin
                nbytes        = 3'd1;
                dec_next.strb = 4'b0001 << req.addr[1:0];
            end
            lsu_pkg::size_half: begin
                nbytes        = 3'd2;
                dec_next.strb = 4'b0011 << req.addr[1:0];  // Misaligned case is faulted anyway
            end
            lsu_pkg::size_word: dec_next.strb = 4'b1111;
            default:            dec_next.strb = 4'b0000;
        endcase
        // A bad size reports nothing else
        dec_next.op_fault     = is_bad;
        dec_next.addr_fault   = !is_bad && misaligned;
        dec_next.access_fault = !is_bad && outside;
    end

    assign req_ready = run && (!dec_valid || dec_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run       <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (req_ready) begin
                dec_valid <= req_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            dec <= dec_next;                       // Decoded payload
        end
    end

    // The slot keeps its request while execute is busy
    a_slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

//--- source/lsu_execute.sv
// AXI4-Lite master with one transaction in flight; faulted requests never touch the bus
`timescale 1ns/1ns

module lsu_execute (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    output logic              dec_ready,
    input  lsu_pkg::lsu_dec_t dec,
    output logic              ex_valid,
    input  logic              ex_ready,
    output lsu_pkg::lsu_dec_t ex_dec,
    output logic [31:0]       ex_rdata,
    output logic              ex_bus_err,
    output logic              awvalid,
    input  logic              awready,
    output lsu_pkg::axi_aw_t  aw,
    output logic              wvalid,
    input  logic              wready,
    output lsu_pkg::axi_w_t   w,
    input  logic              bvalid,
    output logic              bready,
    input  lsu_pkg::axi_b_t   b,
    output logic              arvalid,
    input  logic              arready,
    output lsu_pkg::axi_ar_t  ar,
    input  logic              rvalid,
    output logic              rready,
    input  lsu_pkg::axi_r_t   r
);

    typedef enum logic [2:0] {
        idle,
        write_addr_data,
        write_resp,
        read_addr,
        read_data,
        done
    } state_e;

    state_e state;
    logic   faulted;
    logic   aw_done;
    logic   w_done;

    assign faulted = dec.op_fault || dec.addr_fault || dec.access_fault;
    assign aw_done = !awvalid || awready;          // AW accepted now or earlier
    assign w_done  = !wvalid || wready;

    assign dec_ready = (state == idle);
    assign ex_valid  = (state == done);

    // Bus sees word addresses, lanes are selected by strb
    assign aw = '{addr: {ex_dec.addr[31:2], 2'b00}, prot: 3'b000};
    assign ar = '{addr: {ex_dec.addr[31:2], 2'b00}, prot: 3'b000};
    assign w  = '{data: ex_dec.lane_data, strb: ex_dec.strb};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
            bready  <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (dec_valid) begin
                        if (faulted) begin
                            state <= done;         // Bypass the bus
                        end else if (dec.is_write) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= write_addr_data;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= read_addr;
                        end
                    end
                end
                write_addr_data: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= write_resp;
                    end
                end
                write_resp: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= done;
                    end
                end
                read_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= read_data;
                    end
                end
                read_data: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        state  <= done;
                    end
                end
                default: begin
                    if (ex_ready) state <= idle;   // Held here under back-pressure
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && dec_valid) begin
            ex_dec     <= dec;
            ex_rdata   <= '0;
            ex_bus_err <= 1'b0;
        end
        if (bvalid && bready) begin
            ex_bus_err <= (b.resp != lsu_pkg::axi_resp_okay);
        end
        if (rvalid && rready) begin
            ex_rdata   <= r.data;
            ex_bus_err <= (r.resp != lsu_pkg::axi_resp_okay);
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid);
    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid);
    a_one_channel: assert property (@(posedge clk) disable iff (!arst_n)
        !(awvalid && arvalid));

endmodule

//--- source/lsu_result.sv
// Response register; rdata is zero for writes and any fault, bus errors map to access_fault
`timescale 1ns/1ns

module lsu_result (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    output logic              ex_ready,
    input  lsu_pkg::lsu_dec_t ex_dec,
    input  logic [31:0]       ex_rdata,
    input  logic              ex_bus_err,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::lsu_rsp_t rsp
);

    logic [31:0]       shifted;
    logic [31:0]       extended;
    lsu_pkg::lsu_rsp_t rsp_next;

    assign shifted = ex_rdata >> {ex_dec.addr[1:0], 3'b000};  // Lane down to bit 0

    always_comb begin
        case (ex_dec.size)
            lsu_pkg::size_byte: begin
                extended = ex_dec.is_unsigned ? {24'b0, shifted[7:0]}
                                              : {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::size_half: begin
                extended = ex_dec.is_unsigned ? {16'b0, shifted[15:0]}
                                              : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: extended = ex_rdata;          // Word passes through
        endcase
    end

    always_comb begin
        rsp_next.op_fault     = ex_dec.op_fault;
        rsp_next.addr_fault   = ex_dec.addr_fault;
        rsp_next.access_fault = ex_dec.access_fault || ex_bus_err;
        if (ex_dec.is_write || rsp_next.op_fault || rsp_next.addr_fault ||
            rsp_next.access_fault) begin
            rsp_next.rdata = '0;
        end else begin
            rsp_next.rdata = extended;
        end
    end

    assign ex_ready = !rsp_valid || rsp_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (ex_ready) begin
            rsp_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            rsp <= rsp_next;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- source/lsu_top.sv
// LSU top; window set by win_base and win_size, one AXI4-Lite transaction at a time
`timescale 1ns/1ns

module lsu_top #(
    parameter logic [31:0] win_base = 32'h0000_0000,
    parameter logic [31:0] win_size = 32'h0001_0000
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::lsu_rsp_t rsp,
    output logic              awvalid,
    input  logic              awready,
    output lsu_pkg::axi_aw_t  aw,
    output logic              wvalid,
    input  logic              wready,
    output lsu_pkg::axi_w_t   w,
    input  logic              bvalid,
    output logic              bready,
    input  lsu_pkg::axi_b_t   b,
    output logic              arvalid,
    input  logic              arready,
    output lsu_pkg::axi_ar_t  ar,
    input  logic              rvalid,
    output logic              rready,
    input  lsu_pkg::axi_r_t   r
);

    logic              dec_valid;
    logic              dec_ready;
    lsu_pkg::lsu_dec_t dec;
    logic              ex_valid;
    logic              ex_ready;
    lsu_pkg::lsu_dec_t ex_dec;
    logic [31:0]       ex_rdata;
    logic              ex_bus_err;

    lsu_decode #(
        .win_base (win_base),
        .win_size (win_size)
    ) lsu_decode_inst (
        .clk, .arst_n,
        .req_valid, .req_ready, .req,
        .dec_valid, .dec_ready, .dec
    );

    lsu_execute lsu_execute_inst (
        .clk, .arst_n,
        .dec_valid, .dec_ready, .dec,
        .ex_valid, .ex_ready, .ex_dec, .ex_rdata, .ex_bus_err,
        .awvalid, .awready, .aw,
        .wvalid, .wready, .w,
        .bvalid, .bready, .b,
        .arvalid, .arready, .ar,
        .rvalid, .rready, .r
    );

    lsu_result lsu_result_inst (
        .clk, .arst_n,
        .ex_valid, .ex_ready, .ex_dec, .ex_rdata, .ex_bus_err,
        .rsp_valid, .rsp_ready, .rsp
    );

endmodule

//--- tb/tb_axi_mem.sv
// AXI4-Lite slave of 64 KiB; decodes addr[15:0] only, ready delays of 0 to 3 cycles
`timescale 1ns/1ns

module tb_axi_mem #(
    parameter logic [31:0] err_base = 32'h0000_F000,
    parameter logic [31:0] err_last = 32'h0000_FFFF
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             awvalid,
    output logic             awready,
    input  lsu_pkg::axi_aw_t aw,
    input  logic             wvalid,
    output logic             wready,
    input  lsu_pkg::axi_w_t  w,
    output logic             bvalid,
    input  logic             bready,
    output lsu_pkg::axi_b_t  b,
    input  logic             arvalid,
    output logic             arready,
    input  lsu_pkg::axi_ar_t ar,
    output logic             rvalid,
    input  logic             rready,
    output lsu_pkg::axi_r_t  r
);

    logic [7:0]      mem [0:65535];
    logic [31:0]     waddr;
    logic [31:0]     raddr;
    lsu_pkg::axi_w_t wbeat;

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3C;
    endfunction

    function automatic logic in_err(input logic [31:0] a);
        return (a >= err_base) && (a <= err_last);
    endfunction

    task automatic random_wait();
        repeat ($urandom_range(3, 0)) @(negedge clk);
    endtask

    // Write side, AW first and then W
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_byte(16'(a));
        end
        forever begin
            @(negedge clk);
            if (arst_n && awvalid) begin
                random_wait();
                waddr   = aw.addr;
                awready = 1'b1;                    // Handshake on the next rising edge
                @(negedge clk);
                awready = 1'b0;
                while (!wvalid) @(negedge clk);
                random_wait();
                wbeat  = w;
                wready = 1'b1;
                @(negedge clk);
                wready = 1'b0;
                if (!in_err(waddr)) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wbeat.strb[k]) mem[{waddr[15:2], 2'(k)}] = wbeat.data[8*k +: 8];
                    end
                end
                random_wait();
                b.resp = in_err(waddr) ? 2'b10 : lsu_pkg::axi_resp_okay;  // SLVERR in region
                bvalid = 1'b1;
                while (!bready) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge clk);
            if (arst_n && arvalid) begin
                random_wait();
                raddr   = ar.addr;
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                random_wait();
                r.data = {mem[{raddr[15:2], 2'd3}], mem[{raddr[15:2], 2'd2}],
                          mem[{raddr[15:2], 2'd1}], mem[{raddr[15:2], 2'd0}]};
                r.resp = in_err(raddr) ? 2'b10 : lsu_pkg::axi_resp_okay;
                rvalid = 1'b1;
                while (!rready) @(negedge clk);
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

endmodule

//--- tb/tb_lsu.sv
// Random LSU test; window 0x0000-0xFFFF, memory answers SLVERR from 0xF000 to 0xFFFF
`timescale 1ns/1ns

module tb_lsu;

    localparam logic [31:0] win_base       = 32'h0000_0000;
    localparam logic [31:0] win_size       = 32'h0001_0000;
    localparam logic [31:0] err_base       = 32'h0000_F000;
    localparam logic [31:0] err_last       = 32'h0000_FFFF;
    localparam int          num_reqs       = 2000;
    localparam int          timeout_cycles = num_reqs * 20;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    logic              req_ready;
    lsu_pkg::lsu_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    lsu_pkg::lsu_rsp_t rsp;
    logic              awvalid;
    logic              awready;
    lsu_pkg::axi_aw_t  aw;
    logic              wvalid;
    logic              wready;
    lsu_pkg::axi_w_t   w;
    logic              bvalid;
    logic              bready;
    lsu_pkg::axi_b_t   b;
    logic              arvalid;
    logic              arready;
    lsu_pkg::axi_ar_t  ar;
    logic              rvalid;
    logic              rready;
    lsu_pkg::axi_r_t   r;

    logic [7:0]        mirror [0:65535];       // Expected memory contents
    lsu_pkg::lsu_rsp_t exp_q [$];
    int                checked;
    int                cycles;
    int                bus_exp;                // Clean requests that must reach the bus
    int                bus_seen;

    lsu_top #(
        .win_base (win_base),
        .win_size (win_size)
    ) lsu_top_inst (
        .clk, .arst_n,
        .req_valid, .req_ready, .req,
        .rsp_valid, .rsp_ready, .rsp,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .b,
        .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    tb_axi_mem #(
        .err_base (err_base),
        .err_last (err_last)
    ) axi_mem_inst (
        .clk, .arst_n,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .b,
        .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3C;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        fail_run($sformatf("[FAIL] %s expected %h got %h at response %0d", name, exp, got,
                           checked));
    endtask

    function automatic lsu_pkg::lsu_req_t random_request();
        lsu_pkg::lsu_req_t rq;
        int unsigned       sel;
        sel            = $urandom_range(99, 0);
        rq.is_write    = ($urandom_range(1, 0) == 1);
        rq.is_unsigned = ($urandom_range(1, 0) == 1);
        if ($urandom_range(99, 0) < 8) rq.size = lsu_pkg::size_bad;
        else rq.size = lsu_pkg::lsu_size_e'(2'($urandom_range(2, 0)));
        if (sel < 55) rq.addr = $urandom_range(32'h3F, 0);       // Hot spot where reads meet writes
        else if (sel < 70) rq.addr = err_base + $urandom_range(32'h3F, 0);
        else if (sel < 80) rq.addr = win_size - $urandom_range(8, 1);  // Top edge of window
        else if (sel < 90) rq.addr = $urandom();
        else rq.addr = $urandom_range(32'hFFFF, 0);
        rq.wdata = $urandom();
        return rq;
    endfunction

    // Sequential model holds since the unit keeps order with one bus access at a time
    task automatic model_request(input lsu_pkg::lsu_req_t rq);
        lsu_pkg::lsu_rsp_t exp;
        int                nb;
        logic [32:0]       last;
        logic [31:0]       val;
        logic              clean;
        exp  = '0;
        val  = '0;
        nb   = (rq.size == lsu_pkg::size_byte) ? 1 : (rq.size == lsu_pkg::size_half) ? 2 : 4;
        last = {1'b0, rq.addr} + 33'(nb);
        if (rq.size == lsu_pkg::size_bad) begin
            exp.op_fault = 1'b1;
        end else begin
            exp.addr_fault   = (rq.addr % nb) != 0;
            exp.access_fault = (rq.addr < win_base) ||
                               (last > {1'b0, win_base} + {1'b0, win_size});
            clean = !exp.addr_fault && !exp.access_fault;
            if (clean) bus_exp++;
            if (clean && rq.addr >= err_base && rq.addr <= err_last) begin
                exp.access_fault = 1'b1;           // Bus error leaves memory untouched
            end else if (clean && rq.is_write) begin
                for (int k = 0; k < nb; k++) mirror[16'(rq.addr + 32'(k))] = rq.wdata[8*k +: 8];
            end else if (clean) begin
                for (int k = 0; k < nb; k++) val[8*k +: 8] = mirror[16'(rq.addr + 32'(k))];
                case (nb)
                    1: exp.rdata = rq.is_unsigned ? {24'b0, val[7:0]} : {{24{val[7]}}, val[7:0]};
                    2: exp.rdata = rq.is_unsigned ? {16'b0, val[15:0]}
                                                  : {{16{val[15]}}, val[15:0]};
                    default: exp.rdata = val;
                endcase
            end
        end
        exp_q.push_back(exp);
    endtask

    initial begin
        lsu_pkg::lsu_req_t rq;
        void'($urandom(60158));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        bus_exp   = 0;
        for (int a = 0; a < 65536; a++) mirror[a] = fill_byte(16'(a));
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < num_reqs; i++) begin
            rq        = random_request();
            req       = rq;
            req_valid = 1'b1;
            while (!req_ready) @(negedge clk);     // Transfer on the next rising edge
            model_request(rq);
            @(negedge clk);
            if ($urandom_range(9, 0) == 0) begin
                req_valid = 1'b0;                  // Idle gap
                @(negedge clk);
            end
        end
        req_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);                // Room for a stray response
        $display("%0d responses checked", checked);
        if (bus_seen == bus_exp) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run($sformatf("%0d bus transactions seen for %0d clean requests",
                               bus_seen, bus_exp));
        end
    end

    initial begin
        lsu_pkg::lsu_rsp_t exp;
        checked   = 0;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = ($urandom_range(99, 0) >= 30);
            if (rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0)
                else fail_run("response arrived with no request pending");
                exp = exp_q.pop_front();
                assert (rsp.rdata == exp.rdata)
                else fail_value("rsp.rdata", exp.rdata, rsp.rdata);
                assert ({rsp.op_fault, rsp.addr_fault, rsp.access_fault} ==
                        {exp.op_fault, exp.addr_fault, exp.access_fault})
                else fail_value("rsp.{op,addr,access}_fault",
                                32'({exp.op_fault, exp.addr_fault, exp.access_fault}),
                                32'({rsp.op_fault, rsp.addr_fault, rsp.access_fault}));
                checked++;
            end
        end
    end

    // Each AW or AR valid rise is one bus transaction
    initial begin
        logic aw_prev;
        logic ar_prev;
        aw_prev  = 1'b0;
        ar_prev  = 1'b0;
        bus_seen = 0;
        forever begin
            @(negedge clk);
            if (awvalid) begin
                assert (aw.prot == 3'b000)
                else fail_value("aw.prot", 32'h0, 32'(aw.prot));
            end
            if (arvalid) begin
                assert (ar.prot == 3'b000)
                else fail_value("ar.prot", 32'h0, 32'(ar.prot));
            end
            if ((awvalid && !aw_prev) || (arvalid && !ar_prev)) bus_seen++;
            aw_prev = awvalid;
            ar_prev = arvalid;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= timeout_cycles) fail_run("timeout, responses still missing");
        end
    end

endmodule

//--- filelist.f
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/lsu_result.sv
source/lsu_top.sv
tb/tb_axi_mem.sv
tb/tb_lsu.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_lsu -o sim_lsu

# The log decides the result, so a fatal stop must not end the script here
./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed"
    exit 1
fi
